/* common/turfio_reg_pkg.sv */
package turfio_reg_pkg;

    ////////////////////////////////////////
    // bus widths and address map
    ////////////////////////////////////////

    localparam int NUM_ADR_BITS = 11;

    typedef logic [NUM_ADR_BITS-1:0] wb_adr_t;
    typedef logic [31:0]             wb_data_t;
    typedef logic [3:0]              wb_sel_t;

    // bits 7:6 pick the region, low six bits pick the register
    localparam wb_adr_t DOMAIN_MASK   = 11'h0C0;
    localparam wb_adr_t REGISTER_MASK = 11'h03F;
    localparam wb_adr_t CTRL_DOMAIN   = 11'h000;
    localparam wb_adr_t CNT_DOMAIN    = 11'h040;

    localparam wb_adr_t CONTROL_REG = 11'h000;
    localparam wb_adr_t BIT_ERR_REG = 11'h040;
    localparam wb_adr_t CAPTURE_REG = 11'h044;

    ////////////////////////////////////////
    // payload widths
    ////////////////////////////////////////

    // 56 fine steps per VCO period times 12
    localparam int PS_BITS = 10;
    typedef logic [PS_BITS-1:0] ps_value_t;
    localparam ps_value_t PS_MAX = 10'd671;

    localparam int INTERVAL_BITS = 24;
    typedef logic [INTERVAL_BITS-1:0] interval_t;

    localparam int ERR_COUNT_BITS = 25;
    typedef logic [ERR_COUNT_BITS-1:0] err_count_t;

    localparam int CAPTURE_BITS = 4;
    typedef logic [CAPTURE_BITS-1:0] capture_t;

    ////////////////////////////////////////
    // grouped signals
    ////////////////////////////////////////

    // request as held for the ack cycle
    typedef struct packed {
        wb_adr_t  adr;
        wb_data_t dat;
        wb_sel_t  sel;
        logic     we;
    } wb_req_t;

    typedef struct packed {
        logic cin_rst;
        logic en_vtc;
        logic idelayctrl_rst;
        logic mmcm_rst;
        logic train_en;
        logic aclk_reset;
        logic lock_req;
        logic bitslip;
        logic bitslip_rst;
        logic lock_rst;
    } ctrl_pins_t;

    // raw, not yet synchronized
    typedef struct packed {
        logic idelayctrl_rdy;
        logic mmcm_locked;
        logic aclk_locked;
        logic ifclk_alignerr;
        logic lock_status;
        logic cin_running;
    } status_pins_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_t;

endpackage

/* control/phase_shift_stepper.sv */
module phase_shift_stepper (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    input  turfio_reg_pkg::ps_value_t target_i,
    input  logic                      ps_done_i,
    output logic                      ps_en_o,
    output logic                      incomplete_o
);
    import turfio_reg_pkg::*;

    ps_value_t current_q;
    ps_value_t current_next;
    logic      ps_en_q;
    // a step has been issued and the MMCM has not reported done
    logic      busy_q;

    // fine phase only moves forward, so wrap after the last position
    assign current_next = (current_q == PS_MAX) ? '0 : current_q + ps_value_t'(1);

    ////////////////////////////////////////
    // step sequencing
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            current_q <= '0;
            ps_en_q   <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            ps_en_q <= 1'b0;
            if (busy_q) begin
                if (ps_done_i) begin
                    busy_q <= 1'b0;
                end
            end else if (current_q != target_i) begin
                // issue one step and count it now
                ps_en_q   <= 1'b1;
                busy_q    <= 1'b1;
                current_q <= current_next;
            end
        end
    end

    assign ps_en_o = ps_en_q;

    // done only when settled on target with no step in flight
    assign incomplete_o = (current_q != target_i) || busy_q;

endmodule

/* control/turfio_control_regs.sv */
module turfio_control_regs (
    input  logic                         wb_clk_i,
    input  logic                         wb_rst_i,
    input  turfio_reg_pkg::wb_req_t      req_i,
    input  logic                         ctrl_wr_i,
    input  turfio_reg_pkg::status_pins_t status_i,
    input  logic                         ps_done_i,
    output turfio_reg_pkg::ctrl_pins_t   ctrl_o,
    output turfio_reg_pkg::wb_data_t     ctrl_word_o,
    output logic                         ps_en_o
);
    import turfio_reg_pkg::*;

    // levels
    logic cin_rst_q;
    logic dis_vtc_q;
    logic idelayctrl_rst_q;
    logic mmcm_rst_q;
    logic train_en_q;
    logic lock_req_q;
    logic aclk_reset_q;
    // one-cycle flags
    logic bitslip_rst_q;
    logic bitslip_q;
    logic lock_rst_q;

    ps_value_t    target_q;
    logic         ps_incomplete;
    status_pins_t status_meta_q;
    status_pins_t status_sync_q;
    logic         lock_mux;

    ////////////////////////////////////////
    // register writes by byte lane
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cin_rst_q        <= 1'b0;
            dis_vtc_q        <= 1'b0;
            idelayctrl_rst_q <= 1'b0;
            mmcm_rst_q       <= 1'b0;
            train_en_q       <= 1'b0;
            lock_req_q       <= 1'b0;
            // ACLK PLLs come up held in reset until released by software
            aclk_reset_q     <= 1'b1;
            bitslip_rst_q    <= 1'b0;
            bitslip_q        <= 1'b0;
            lock_rst_q       <= 1'b0;
            target_q         <= '0;
        end else begin
            bitslip_rst_q <= 1'b0;
            bitslip_q     <= 1'b0;
            lock_rst_q    <= 1'b0;
            if (ctrl_wr_i) begin
                if (req_i.sel[0]) begin
                    cin_rst_q        <= req_i.dat[0];
                    dis_vtc_q        <= req_i.dat[1];
                    idelayctrl_rst_q <= req_i.dat[2];
                    mmcm_rst_q       <= req_i.dat[4];
                    train_en_q       <= req_i.dat[6];
                end
                if (req_i.sel[1]) begin
                    bitslip_rst_q <= req_i.dat[8];
                    bitslip_q     <= req_i.dat[9];
                    lock_rst_q    <= req_i.dat[10];
                    lock_req_q    <= req_i.dat[11];
                    aclk_reset_q  <= req_i.dat[13];
                end
                // target needs both upper lanes
                if (req_i.sel[2] && req_i.sel[3]) begin
                    target_q <= req_i.dat[16 +: PS_BITS];
                end
            end
        end
    end

    // two-flop synchronizer for all status inputs
    always_ff @(posedge wb_clk_i) begin
        status_meta_q <= status_i;
        status_sync_q <= status_meta_q;
    end

    // one read bit shared, lock_req picks the source
    assign lock_mux = lock_req_q ? status_sync_q.lock_status : status_sync_q.cin_running;

    phase_shift_stepper u_stepper (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
        .target_i(target_q), .ps_done_i(ps_done_i),
        .ps_en_o(ps_en_o), .incomplete_o(ps_incomplete)
    );

    ////////////////////////////////////////
    // pins and read-back
    ////////////////////////////////////////

    assign ctrl_o.cin_rst        = cin_rst_q;
    assign ctrl_o.en_vtc         = ~dis_vtc_q;
    assign ctrl_o.idelayctrl_rst = idelayctrl_rst_q;
    assign ctrl_o.mmcm_rst       = mmcm_rst_q;
    assign ctrl_o.train_en       = train_en_q;
    assign ctrl_o.aclk_reset     = aclk_reset_q;
    assign ctrl_o.lock_req       = lock_req_q;
    assign ctrl_o.bitslip        = bitslip_q;
    assign ctrl_o.bitslip_rst    = bitslip_rst_q;
    assign ctrl_o.lock_rst       = lock_rst_q;

    assign ctrl_word_o = {ps_incomplete, {(15 - PS_BITS){1'b0}}, target_q,
                          status_sync_q.ifclk_alignerr, status_sync_q.aclk_locked,
                          aclk_reset_q, lock_mux, lock_req_q, lock_rst_q,
                          bitslip_q, bitslip_rst_q, 1'b0, train_en_q,
                          status_sync_q.mmcm_locked, mmcm_rst_q,
                          status_sync_q.idelayctrl_rdy, idelayctrl_rst_q,
                          dis_vtc_q, cin_rst_q};

endmodule

/* errcnt/timed_error_counter.sv */
module timed_error_counter (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  turfio_reg_pkg::interval_t  interval_i,
    input  logic                       interval_load_i,
    input  logic                       err_i,
    output turfio_reg_pkg::err_count_t count_o
);
    import turfio_reg_pkg::*;

    interval_t  interval_q;
    interval_t  timer_q;
    err_count_t acc_q;
    err_count_t acc_next;
    err_count_t count_q;
    logic       err_q;
    logic       window_end;

    // error input registered once before counting
    always_ff @(posedge wb_clk_i) begin
        err_q <= err_i;
    end

    assign acc_next   = acc_q + err_count_t'(err_q);
    assign window_end = (timer_q == interval_q - interval_t'(1));

    ////////////////////////////////////////
    // window timer and accumulator
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            interval_q <= '0;
            timer_q    <= '0;
            acc_q      <= '0;
            count_q    <= '0;
        end else if (interval_load_i) begin
            // new interval restarts the window, last result stays visible
            interval_q <= interval_i;
            timer_q    <= '0;
            acc_q      <= '0;
        end else if (interval_q != '0) begin
            if (window_end) begin
                count_q <= acc_next;
                acc_q   <= '0;
                timer_q <= '0;
            end else begin
                acc_q   <= acc_next;
                timer_q <= timer_q + interval_t'(1);
            end
        end
        // zero interval leaves everything frozen
    end

    assign count_o = count_q;

endmodule

/* sim/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

////////////////////////////////////////
// compare and bus access
////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
endtask

// one access, drives at the rising edge and samples mid-cycle
task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t dat,
                         input wb_sel_t sel, output wb_data_t rdata);
    int waited;
    rdata = '0;
    waited = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    do begin
        @(negedge wb_clk_i);
        waited++;
    end while (!wb_ack_o && waited < ACK_TIMEOUT);
    if (!wb_ack_o) begin
        timeout_abort("the bus target never acknowledged an access");
    end else begin
        rdata = wb_dat_o;
        check_value("ack latency", waited, 2);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge wb_clk_i);
        // a second ack here would be a double acknowledge
        check_value("wb_ack_o after ack", wb_ack_o, 0);
    end
endtask

task automatic write_reg(input wb_adr_t adr, input wb_data_t dat, input wb_sel_t sel);
    wb_data_t unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
endtask

task automatic read_reg(input wb_adr_t adr, output wb_data_t dat);
    bus_cycle(1'b0, adr, '0, 4'b1111, dat);
endtask

// polls the control word until ps_incomplete drops
task automatic wait_phase_done(output wb_data_t word);
    int polls;
    polls = 0;
    read_reg(CONTROL_REG, word);
    while (word[31] && polls < PHASE_TIMEOUT) begin
        read_reg(CONTROL_REG, word);
        polls++;
    end
    if (word[31]) begin
        timeout_abort("the phase shift never reached its target");
    end
endtask

`endif

/* sim/tb_turfio_register_core.sv */
module tb_turfio_register_core;
    import turfio_reg_pkg::*;

    localparam int ACK_TIMEOUT     = 16;
    localparam int PHASE_TIMEOUT   = 5000;
    localparam int PHASE_POSITIONS = PS_MAX + 1;

    logic       wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    wb_adr_t    wb_adr_i;
    wb_data_t   wb_dat_i, wb_dat_o;
    wb_sel_t    wb_sel_i;
    logic       capture_err_i, ps_done_i, idelayctrl_rdy_i, mmcm_locked_i, aclk_locked_i;
    logic       ifclk_alignerr_i, lock_status_i, cin_running_i;
    capture_t   capture_data_i;
    logic       ps_en_o, capture_req_o, cin_rst_o, en_vtc_o, idelayctrl_rst_o, mmcm_rst_o;
    logic       aclk_reset_o, lock_req_o, bitslip_o, bitslip_rst_o, lock_rst_o;
    logic [1:0] train_en_o;

    int          error_count, check_count;
    int          ps_en_count, bitslip_count, capture_req_count;
    int unsigned seed_init;
    logic        ps_en_seen, err_toggle, err_level;
    logic [1:0]  done_pipe;

    turfio_register_core uut (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .capture_err_i(capture_err_i),
        .ps_done_i(ps_done_i), .idelayctrl_rdy_i(idelayctrl_rdy_i),
        .mmcm_locked_i(mmcm_locked_i), .aclk_locked_i(aclk_locked_i),
        .ifclk_alignerr_i(ifclk_alignerr_i), .lock_status_i(lock_status_i),
        .cin_running_i(cin_running_i), .capture_data_i(capture_data_i),
        .ps_en_o(ps_en_o), .capture_req_o(capture_req_o), .cin_rst_o(cin_rst_o),
        .en_vtc_o(en_vtc_o), .idelayctrl_rst_o(idelayctrl_rst_o), .mmcm_rst_o(mmcm_rst_o),
        .aclk_reset_o(aclk_reset_o), .lock_req_o(lock_req_o), .bitslip_o(bitslip_o),
        .bitslip_rst_o(bitslip_rst_o), .lock_rst_o(lock_rst_o), .train_en_o(train_en_o)
    );

    task automatic finish_run();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        error_count++;
        $display("Timeout at %0t: %s", $time, what);
        finish_run();
    endtask

    `include "tb_bus_tasks.svh"

    always #10 wb_clk_i = ~wb_clk_i;

    ////////////////////////////////////////
    // MMCM and capture side models
    ////////////////////////////////////////

    // pulse counters sampled mid-cycle
    always @(negedge wb_clk_i) begin
        ps_en_seen = ps_en_o;
        if (ps_en_o)
            ps_en_count++;
        if (bitslip_o)
            bitslip_count++;
        if (capture_req_o)
            capture_req_count++;
    end

    // ps_done follows each step request by three cycles
    always @(posedge wb_clk_i) begin
        done_pipe <= {done_pipe[0], ps_en_seen};
        ps_done_i <= done_pipe[1];
    end

    always @(posedge wb_clk_i) begin
        if (err_toggle)
            capture_err_i <= ~capture_err_i;
        else
            capture_err_i <= err_level;
    end

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic reset_and_ack();
        wb_data_t word;
        read_reg(CONTROL_REG, word);
        // only aclk_reset set with all status inputs low
        check_value("control word", word, 32'h0000_2000);
        check_value("aclk_reset_o", aclk_reset_o, 1);
        check_value("en_vtc_o", en_vtc_o, 1);
        check_value("cin_rst_o", cin_rst_o, 0);
        check_value("idelayctrl_rst_o", idelayctrl_rst_o, 0);
        check_value("mmcm_rst_o", mmcm_rst_o, 0);
        check_value("train_en_o", train_en_o, 0);
        check_value("lock_req_o", lock_req_o, 0);
        check_value("pulse outputs", {bitslip_o, bitslip_rst_o, lock_rst_o, ps_en_o}, 0);
    endtask

    task automatic control_levels();
        wb_data_t wdata, word, kept;
        for (int i = 0; i < 4; i++) begin
            wdata = $urandom & 32'h0000_2857;
            // last pass leaves both lane 1 levels set
            if (i == 3) begin
                wdata = wdata | 32'h0000_2800;
            end
            write_reg(CONTROL_REG, wdata, 4'b0011);
            check_value("cin_rst_o", cin_rst_o, wdata[0]);
            check_value("en_vtc_o", en_vtc_o, !wdata[1]);
            check_value("idelayctrl_rst_o", idelayctrl_rst_o, wdata[2]);
            check_value("mmcm_rst_o", mmcm_rst_o, wdata[4]);
            check_value("train_en_o", train_en_o, {2{wdata[6]}});
            check_value("lock_req_o", lock_req_o, wdata[11]);
            check_value("aclk_reset_o", aclk_reset_o, wdata[13]);
            read_reg(CONTROL_REG, word);
            check_value("control levels", word & 32'h0000_2857, wdata);
        end
        // lane 1 deselected so its levels hold
        kept = wdata;
        wdata = ~kept & 32'h0000_2857;
        write_reg(CONTROL_REG, wdata, 4'b0001);
        read_reg(CONTROL_REG, word);
        check_value("lane 0 levels", word & 32'h57, wdata & 32'h57);
        check_value("lane 1 levels", word & 32'h2800, kept & 32'h2800);
    endtask

    task automatic status_and_flags();
        logic [5:0] st;
        wb_data_t   word, expected;
        int         base;
        for (int i = 0; i < 4; i++) begin
            if (i % 2 == 0) begin
                st = $urandom;
            end else begin
                st = ~st;
            end
            // lock_status and cin_running differ so the mux choice shows
            st[0] = ~st[1];
            write_reg(CONTROL_REG, (i % 2) << 11, 4'b0010);
            @(posedge wb_clk_i);
            {idelayctrl_rdy_i, mmcm_locked_i, aclk_locked_i} <= st[5:3];
            {ifclk_alignerr_i, lock_status_i, cin_running_i} <= st[2:0];
            repeat (3) @(posedge wb_clk_i);
            read_reg(CONTROL_REG, word);
            expected = '0;
            expected[3]  = st[5];
            expected[5]  = st[4];
            expected[11] = i % 2;
            expected[12] = (i % 2) ? st[1] : st[0];
            expected[14] = st[3];
            expected[15] = st[2];
            check_value("status bits", word & 32'h0000_D828, expected);
        end
        base = bitslip_count;
        write_reg(CONTROL_REG, 32'h0000_0200, 4'b0010);
        read_reg(CONTROL_REG, word);
        check_value("bitslip_o pulses", bitslip_count - base, 1);
        check_value("bitslip read-back", word[9], 0);
    endtask

    task automatic phase_shift();
        ps_value_t targets[2] = '{10'd5, 10'd2};
        ps_value_t prev;
        wb_data_t  word;
        int        base, steps;
        prev = '0;
        for (int i = 0; i < 2; i++) begin
            base = ps_en_count;
            // forward only so a lower target wraps through PS_MAX
            steps = (int'(targets[i]) - int'(prev) + PHASE_POSITIONS) % PHASE_POSITIONS;
            write_reg(CONTROL_REG, wb_data_t'(targets[i]) << 16, 4'b1100);
            wait_phase_done(word);
            check_value("ps_en_o pulses", ps_en_count - base, steps);
            check_value("target read-back", word[25:16], targets[i]);
            prev = targets[i];
        end
    endtask

    task automatic error_counter();
        wb_data_t word;
        err_toggle = 1'b0;
        err_level  = 1'b1;
        repeat (2) @(posedge wb_clk_i);
        write_reg(BIT_ERR_REG, 32'd40, 4'b1111);
        repeat (40 + 2) @(posedge wb_clk_i);
        read_reg(BIT_ERR_REG, word);
        check_value("error count, held high", word, 40);
        err_toggle = 1'b1;
        write_reg(BIT_ERR_REG, 32'd40, 4'b1111);
        repeat (40 + 2) @(posedge wb_clk_i);
        read_reg(BIT_ERR_REG, word);
        check_value("error count, alternating", word, 20);
        err_toggle = 1'b0;
        err_level  = 1'b0;
    endtask

    task automatic capture_access();
        wb_data_t word;
        capture_t data;
        int       base;
        // nonzero so it differs from the idle input value
        data = capture_t'(1 + $urandom % 15);
        @(posedge wb_clk_i);
        capture_data_i <= data;
        base = capture_req_count;
        read_reg(CAPTURE_REG, word);
        check_value("capture data", word, data);
        check_value("capture_req_o pulses", capture_req_count - base, 1);
    endtask

    initial begin
        {wb_clk_i, wb_cyc_i, wb_stb_i, wb_we_i} = '0;
        wb_rst_i = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        {capture_err_i, ps_done_i, idelayctrl_rdy_i, mmcm_locked_i, aclk_locked_i} = '0;
        {ifclk_alignerr_i, lock_status_i, cin_running_i} = '0;
        capture_data_i = '0;
        {ps_en_seen, err_toggle, err_level} = '0;
        done_pipe = '0;
        seed_init = $urandom(48257);
        repeat (16) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        reset_and_ack();
        control_levels();
        status_and_flags();
        phase_shift();
        error_counter();
        capture_access();
        finish_run();
    end

endmodule

/* verilog/turfio_register_core.sv */
module turfio_register_core (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  turfio_reg_pkg::wb_adr_t   wb_adr_i,
    input  turfio_reg_pkg::wb_data_t  wb_dat_i,
    input  turfio_reg_pkg::wb_sel_t   wb_sel_i,
    output turfio_reg_pkg::wb_data_t  wb_dat_o,
    output logic                      wb_ack_o,
    input  logic                      capture_err_i,
    input  logic                      ps_done_i,
    input  logic                      idelayctrl_rdy_i,
    input  logic                      mmcm_locked_i,
    input  logic                      aclk_locked_i,
    input  logic                      ifclk_alignerr_i,
    input  logic                      lock_status_i,
    input  logic                      cin_running_i,
    input  turfio_reg_pkg::capture_t  capture_data_i,
    output logic                      ps_en_o,
    output logic                      capture_req_o,
    output logic                      cin_rst_o,
    output logic                      en_vtc_o,
    output logic                      idelayctrl_rst_o,
    output logic                      mmcm_rst_o,
    output logic                      aclk_reset_o,
    output logic                      lock_req_o,
    output logic                      bitslip_o,
    output logic                      bitslip_rst_o,
    output logic                      lock_rst_o,
    output logic [1:0]                train_en_o
);
    import turfio_reg_pkg::*;

    wb_req_t      req;
    logic         ctrl_wr;
    logic         interval_load;
    wb_data_t     ctrl_word;
    err_count_t   err_count;
    ctrl_pins_t   ctrl;
    status_pins_t status;

    assign status = status_pins_t'{
        idelayctrl_rdy: idelayctrl_rdy_i,
        mmcm_locked:    mmcm_locked_i,
        aclk_locked:    aclk_locked_i,
        ifclk_alignerr: ifclk_alignerr_i,
        lock_status:    lock_status_i,
        cin_running:    cin_running_i
    };

    wb_target_port u_port (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .ctrl_word_i(ctrl_word), .err_count_i(err_count),
        .capture_data_i(capture_data_i), .req_o(req),
        .ctrl_wr_o(ctrl_wr), .interval_load_o(interval_load),
        .capture_req_o(capture_req_o)
    );

    turfio_control_regs u_ctrl (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
        .req_i(req), .ctrl_wr_i(ctrl_wr), .status_i(status),
        .ps_done_i(ps_done_i), .ctrl_o(ctrl),
        .ctrl_word_o(ctrl_word), .ps_en_o(ps_en_o)
    );

    // interval lives in the low bits of the write data
    timed_error_counter u_errcnt (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
        .interval_i(req.dat[INTERVAL_BITS-1:0]),
        .interval_load_i(interval_load),
        .err_i(capture_err_i), .count_o(err_count)
    );

    assign cin_rst_o        = ctrl.cin_rst;
    assign en_vtc_o         = ctrl.en_vtc;
    assign idelayctrl_rst_o = ctrl.idelayctrl_rst;
    assign mmcm_rst_o       = ctrl.mmcm_rst;
    assign aclk_reset_o     = ctrl.aclk_reset;
    assign lock_req_o       = ctrl.lock_req;
    assign bitslip_o        = ctrl.bitslip;
    assign bitslip_rst_o    = ctrl.bitslip_rst;
    assign lock_rst_o       = ctrl.lock_rst;
    // COUT and DOUT training share one enable
    assign train_en_o       = {2{ctrl.train_en}};

endmodule

/* verilog/wb_target_port.sv */
module wb_target_port (
    input  logic                       wb_clk_i,
    input  logic                       wb_rst_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  turfio_reg_pkg::wb_adr_t    wb_adr_i,
    input  turfio_reg_pkg::wb_data_t   wb_dat_i,
    input  turfio_reg_pkg::wb_sel_t    wb_sel_i,
    output turfio_reg_pkg::wb_data_t   wb_dat_o,
    output logic                       wb_ack_o,
    input  turfio_reg_pkg::wb_data_t   ctrl_word_i,
    input  turfio_reg_pkg::err_count_t err_count_i,
    input  turfio_reg_pkg::capture_t   capture_data_i,
    output turfio_reg_pkg::wb_req_t    req_o,
    output logic                       ctrl_wr_o,
    output logic                       interval_load_o,
    output logic                       capture_req_o
);
    import turfio_reg_pkg::*;

    bus_state_t state_q;
    wb_req_t    req_q;
    wb_data_t   rdata_q;
    wb_data_t   rdata_sel;
    logic       req_start;
    logic       ack_cycle;

    function automatic logic domain_match(input wb_adr_t adr, input wb_adr_t dom);
        return (adr & DOMAIN_MASK) == (dom & DOMAIN_MASK);
    endfunction

    function automatic logic full_match(input wb_adr_t adr, input wb_adr_t reg_adr);
        return domain_match(adr, reg_adr) &&
               ((adr & REGISTER_MASK) == (reg_adr & REGISTER_MASK));
    endfunction

    assign req_start = wb_cyc_i && wb_stb_i && (state_q == BUS_IDLE);
    assign ack_cycle = (state_q == BUS_ACK);

    ////////////////////////////////////////
    // request capture
    ////////////////////////////////////////

    // data merges byte-wise, unselected lanes keep the old value
    always_ff @(posedge wb_clk_i) begin
        if (req_start) begin
            for (int i = 0; i < 4; i++) begin
                if (wb_sel_i[i]) begin
                    req_q.dat[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
            req_q.adr <= wb_adr_i;
            req_q.sel <= wb_sel_i;
            req_q.we  <= wb_we_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                BUS_IDLE: if (wb_cyc_i && wb_stb_i) state_q <= BUS_ACK;
                BUS_ACK:  state_q <= BUS_IDLE;
                default:  state_q <= BUS_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // read data
    ////////////////////////////////////////

    always_comb begin
        if (domain_match(wb_adr_i, CTRL_DOMAIN)) begin
            rdata_sel = ctrl_word_i;
        end else if (full_match(wb_adr_i, BIT_ERR_REG)) begin
            rdata_sel = wb_data_t'(err_count_i);
        end else if (full_match(wb_adr_i, CAPTURE_REG)) begin
            rdata_sel = wb_data_t'(capture_data_i);
        end else begin
            rdata_sel = '0;
        end
    end

    // sampled on the request cycle, held through ack
    always_ff @(posedge wb_clk_i) begin
        if (req_start) begin
            rdata_q <= rdata_sel;
        end
    end

    // strobes to the blocks, all on the ack cycle
    assign ctrl_wr_o       = ack_cycle && req_q.we && domain_match(req_q.adr, CTRL_DOMAIN);
    assign interval_load_o = ack_cycle && req_q.we && full_match(req_q.adr, BIT_ERR_REG);
    // reads and writes both request a capture
    assign capture_req_o   = ack_cycle && full_match(req_q.adr, CAPTURE_REG);

    assign req_o    = req_q;
    assign wb_dat_o = rdata_q;
    assign wb_ack_o = ack_cycle;

endmodule

/* vlog.f */
+incdir+sim
common/turfio_reg_pkg.sv
control/phase_shift_stepper.sv
control/turfio_control_regs.sv
errcnt/timed_error_counter.sv
verilog/wb_target_port.sv
verilog/turfio_register_core.sv
sim/tb_turfio_register_core.sv
